/* sys_time_sync.f */
sys_time_pkg.sv
lap_divider.sv
pipe_addsub.sv
sys_time_sync.sv
sync_regs.sv
sys_time_top.sv
tb_clock_gen.sv
tb_sys_time.sv

/* Makefile */
VERILATOR  := verilator
VFLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing --assert
TOP        := tb_sys_time
FILELIST   := sys_time_sync.f
OBJ_DIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* tb_sys_time.sv */
//////////////////////////////////////////////////
// Testbench for the sync-locked time generator.
// Programs a reference time over AXI4-Lite, sends
// sync pulses on, late and early of the grid, and
// checks load, lock and the hold/skip correction.
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_sys_time;

  localparam int unsigned SYNC_TICKS = 10240;
  localparam logic [63:0] SYNC_NS = 64'd500000;
  localparam int unsigned SETTLE = 200;  // lock is checked this long after sync.
  localparam int unsigned CYCLE_LIMIT = 8 * SYNC_TICKS + 2000;

  logic CLK;
  logic rst_n;
  sys_time_pkg::axi_addr_t s_axi_awaddr;
  logic s_axi_awvalid;
  logic s_axi_awready;
  sys_time_pkg::axi_data_t s_axi_wdata;
  logic [3:0] s_axi_wstrb;
  logic s_axi_wvalid;
  logic s_axi_wready;
  logic [1:0] s_axi_bresp;
  logic s_axi_bvalid;
  logic s_axi_bready;
  sys_time_pkg::axi_addr_t s_axi_araddr;
  logic s_axi_arvalid;
  logic s_axi_arready;
  sys_time_pkg::axi_data_t s_axi_rdata;
  logic [1:0] s_axi_rresp;
  logic s_axi_rvalid;
  logic s_axi_rready;
  logic ecat_sync;
  sys_time_pkg::sys_time_t sys_time;
  logic sync;
  logic skip_one;

  int unsigned cycles = 0;
  int unsigned rise_cycle = 0;
  int unsigned checks = 0;
  int unsigned errors = 0;
  logic [63:0] ref_ns = '0;
  logic load_armed = 1'b0;
  int unsigned late_d;
  int unsigned early_d;

  // monitor state.
  logic ecat_prev = 1'b0;
  logic load_taken = 1'b0;
  logic in_period = 1'b0;
  logic [63:0] grid = '0;
  int unsigned sync_delay = 4;
  int unsigned neg_count = 0;
  int unsigned last_rise = 0;
  int unsigned period_len = 0;
  int unsigned age = 0;
  int unsigned track_from = 0;
  int unsigned skip_cnt = 0;
  int unsigned exp_skips = 0;
  int unsigned slip_cnt = 0;

  tb_clock_gen clk_gen (
    .CLK   (CLK),
    .rst_n (rst_n)
  );

  sys_time_top UUT (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .ecat_sync     (ecat_sync),
    .sys_time      (sys_time),
    .sync          (sync),
    .skip_one      (skip_one)
  );

  // whole sync periods in the reference scaled to ticks.
  function automatic logic [63:0] expected_load(input logic [63:0] ns);
    return (ns / SYNC_NS) * 64'(SYNC_TICKS);
  endfunction

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic end_period_checks();
    check_value("skip_one pulses in sync period", 64'(skip_cnt), 64'(exp_skips));
    check_value("cycles off the grid after settling", 64'(slip_cnt), 64'd0);
  endtask

  task automatic axi_write(input sys_time_pkg::axi_addr_t addr,
                           input sys_time_pkg::axi_data_t data, input logic [3:0] strb);
    @(posedge CLK);
    s_axi_awaddr  <= addr;
    s_axi_awvalid <= 1'b1;
    s_axi_wdata   <= data;
    s_axi_wstrb   <= strb;
    s_axi_wvalid  <= 1'b1;
    s_axi_bready  <= 1'b1;
    @(negedge CLK);
    while (!s_axi_awready) @(negedge CLK);
    check_value("wready with awready", 64'(s_axi_wready), 64'd1);
    @(posedge CLK);
    s_axi_awvalid <= 1'b0;
    s_axi_wvalid  <= 1'b0;
    @(negedge CLK);
    while (!s_axi_bvalid) @(negedge CLK);
    check_value("write response", 64'(s_axi_bresp), 64'd0);
    @(posedge CLK);
    s_axi_bready <= 1'b0;
  endtask

  task automatic read_check(input sys_time_pkg::axi_addr_t addr,
                            input sys_time_pkg::axi_data_t exp, input string what);
    @(posedge CLK);
    s_axi_araddr  <= addr;
    s_axi_arvalid <= 1'b1;
    s_axi_rready  <= 1'b1;
    @(negedge CLK);
    while (!s_axi_arready) @(negedge CLK);
    @(posedge CLK);
    s_axi_arvalid <= 1'b0;
    @(negedge CLK);
    while (!s_axi_rvalid) @(negedge CLK);
    check_value(what, 64'(s_axi_rdata), 64'(exp));
    check_value("read response", 64'(s_axi_rresp), 64'd0);
    @(posedge CLK);
    s_axi_rready <= 1'b0;
  endtask

  // raises ecat_sync for four cycles once period edges have passed since the last rise.
  task automatic send_sync(input int unsigned period);
    @(posedge CLK);
    while (cycles < rise_cycle + period) @(posedge CLK);
    ecat_sync <= 1'b1;
    rise_cycle = cycles;
    repeat (4) @(posedge CLK);
    ecat_sync <= 1'b0;
  endtask

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d clock cycles.", CYCLE_LIMIT);
      $display("checks: %0d, errors: %0d", checks, errors);
      $display("Result: FAILED");
      $finish;
    end
  end

  // tracks the expected grid time and checks each sync period.
  always @(negedge CLK) begin
    if (rst_n) begin
      if (ecat_sync && !ecat_prev) begin
        sync_delay = 0;
        period_len = neg_count - last_rise;
        last_rise  = neg_count;
      end else if (sync_delay < 4) begin
        sync_delay++;
      end
      if (sync_delay == 2) begin
        check_value("sync pulse from ecat_sync", 64'(sync), 64'd1);
      end
      if (sync_delay == 3) begin
        check_value("sync pulse width", 64'(sync), 64'd0);
        if (in_period) end_period_checks();
        if (load_armed && !load_taken) begin
          grid       = expected_load(ref_ns);
          exp_skips  = 0;
          track_from = 0;  // a load must count from the first cycle.
          load_taken = 1'b1;
          check_value("sys_time after load", sys_time, grid);
        end else begin
          grid       = grid + 64'(SYNC_TICKS);
          exp_skips  = (period_len < SYNC_TICKS) ? SYNC_TICKS - period_len : 0;
          track_from = SETTLE;
        end
        age       = 0;
        skip_cnt  = 0;
        slip_cnt  = 0;
        in_period = 1'b1;
      end
      if (in_period) begin
        if (skip_one) skip_cnt++;
        if (age == SETTLE) begin
          check_value("sys_time settled after sync", sys_time, grid + 64'(SETTLE));
        end
        if (age >= track_from && sys_time != grid + 64'(age)) slip_cnt++;
        age++;
      end
      ecat_prev = ecat_sync;
      neg_count++;
    end
  end

  initial begin
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    ecat_sync     = 1'b0;
    void'($urandom(32'h00325c94));

    wait (rst_n);
    repeat (2) @(posedge CLK);

    // register access and byte strobes.
    axi_write(sys_time_pkg::REG_TIME_LO, 32'h1234_5678, 4'hF);
    axi_write(sys_time_pkg::REG_TIME_LO, 32'hAABB_CCDD, 4'b0101);
    read_check(sys_time_pkg::REG_TIME_LO, 32'h12BB_56DD, "time_lo after strobed write");
    axi_write(sys_time_pkg::REG_TIME_HI, 32'h0BAD_F00D, 4'hF);
    read_check(sys_time_pkg::REG_TIME_HI, 32'h0BAD_F00D, "time_hi readback");
    read_check(4'h2, 32'h0, "unmapped offset");
    read_check(sys_time_pkg::REG_CTRL, 32'h0, "ctrl reads as zero");

    ref_ns = {$urandom, $urandom};
    axi_write(sys_time_pkg::REG_TIME_HI, ref_ns[63:32], 4'hF);
    axi_write(sys_time_pkg::REG_TIME_LO, ref_ns[31:0], 4'hF);
    read_check(sys_time_pkg::REG_TIME_LO, ref_ns[31:0], "reference lo readback");
    read_check(sys_time_pkg::REG_TIME_HI, ref_ns[63:32], "reference hi readback");

    // arm the set and let the divider finish.
    axi_write(sys_time_pkg::REG_CTRL, 32'h1, 4'hF);
    load_armed = 1'b1;
    read_check(sys_time_pkg::REG_STATUS, 32'h1, "status with set pending");
    repeat (80) @(posedge CLK);

    send_sync(0);
    read_check(sys_time_pkg::REG_STATUS, 32'h2, "status after load");
    send_sync(SYNC_TICKS);
    send_sync(SYNC_TICKS);

    late_d = 1 + ($urandom % 20);
    send_sync(SYNC_TICKS + late_d);
    send_sync(SYNC_TICKS);
    early_d = 1 + ($urandom % 20);
    send_sync(SYNC_TICKS - early_d);
    send_sync(SYNC_TICKS);

    repeat (SETTLE + 100) @(posedge CLK);
    end_period_checks();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
//////////////////////////////////////////////////
// Testbench clock and reset source. 20 ns clock,
// rst_n held low for the first 8 rising edges.
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic CLK,
  output logic rst_n
);

  localparam int HALF_PERIOD = 10;
  localparam int RESET_CYCLES = 8;

  initial begin
    CLK = 1'b0;
    forever #HALF_PERIOD CLK = ~CLK;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    rst_n <= 1'b1;  // released on an edge, flops stay reset on it.
  end

endmodule

`default_nettype wire

/* sys_time_top.sv */
//////////////////////////////////////////////////
// Top of the sync-locked time generator. Host
// programs the reference over AXI4-Lite, ecat_sync
// comes straight from the pin.
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module sys_time_top (
  input  wire                       CLK,
  input  wire                       rst_n,
  input  wire sys_time_pkg::axi_addr_t s_axi_awaddr,
  input  wire                       s_axi_awvalid,
  output logic                      s_axi_awready,
  input  wire sys_time_pkg::axi_data_t s_axi_wdata,
  input  wire [3:0]                 s_axi_wstrb,
  input  wire                       s_axi_wvalid,
  output logic                      s_axi_wready,
  output logic [1:0]                s_axi_bresp,
  output logic                      s_axi_bvalid,
  input  wire                       s_axi_bready,
  input  wire sys_time_pkg::axi_addr_t s_axi_araddr,
  input  wire                       s_axi_arvalid,
  output logic                      s_axi_arready,
  output sys_time_pkg::axi_data_t   s_axi_rdata,
  output logic [1:0]                s_axi_rresp,
  output logic                      s_axi_rvalid,
  input  wire                       s_axi_rready,
  input  wire                       ecat_sync,
  output sys_time_pkg::sys_time_t   sys_time,
  output logic                      sync,
  output logic                      skip_one
);

  sys_time_pkg::sys_time_t ref_time;
  sys_time_pkg::lap_t lap;
  logic set_req;
  logic lap_done;
  logic set_pending;
  logic lap_valid;

  sync_regs u_regs (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .set_pending   (set_pending),
    .lap_valid     (lap_valid),
    .ref_time      (ref_time),
    .set_req       (set_req)
  );

  // set_req also kicks off the division.
  lap_divider u_div (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .start    (set_req),
    .ref_time (ref_time),
    .lap      (lap),
    .lap_done (lap_done)
  );

  sys_time_sync u_core (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .ecat_sync   (ecat_sync),
    .set_req     (set_req),
    .lap         (lap),
    .lap_done    (lap_done),
    .sys_time    (sys_time),
    .sync        (sync),
    .skip_one    (skip_one),
    .set_pending (set_pending),
    .lap_valid   (lap_valid)
  );

endmodule

`default_nettype wire

/* sync_regs.sv */
//////////////////////////////////////////////////
// AXI4-Lite register block. Holds the reference
// time, issues the set command and reports status.
// One outstanding transaction per direction.
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module sync_regs (
  input  wire                       CLK,
  input  wire                       rst_n,
  input  wire sys_time_pkg::axi_addr_t s_axi_awaddr,
  input  wire                       s_axi_awvalid,
  output logic                      s_axi_awready,
  input  wire sys_time_pkg::axi_data_t s_axi_wdata,
  input  wire [3:0]                 s_axi_wstrb,
  input  wire                       s_axi_wvalid,
  output logic                      s_axi_wready,
  output logic [1:0]                s_axi_bresp,
  output logic                      s_axi_bvalid,
  input  wire                       s_axi_bready,
  input  wire sys_time_pkg::axi_addr_t s_axi_araddr,
  input  wire                       s_axi_arvalid,
  output logic                      s_axi_arready,
  output sys_time_pkg::axi_data_t   s_axi_rdata,
  output logic [1:0]                s_axi_rresp,
  output logic                      s_axi_rvalid,
  input  wire                       s_axi_rready,
  input  wire                       set_pending,
  input  wire                       lap_valid,
  output sys_time_pkg::sys_time_t   ref_time,
  output logic                      set_req
);

  logic aw_en;
  logic wr_fire;
  logic ar_en;
  logic rd_fire;
  sys_time_pkg::axi_data_t rd_mux;

  assign aw_en = s_axi_awvalid & s_axi_wvalid & ~s_axi_awready & ~s_axi_bvalid;
  assign wr_fire = s_axi_awready & s_axi_awvalid & s_axi_wvalid;
  assign ar_en = s_axi_arvalid & ~s_axi_arready & ~s_axi_rvalid;
  assign rd_fire = s_axi_arready & s_axi_arvalid;

  assign s_axi_bresp = 2'b00;  // always OKAY.
  assign s_axi_rresp = 2'b00;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      s_axi_awready <= 1'b0;
      s_axi_wready  <= 1'b0;
      s_axi_bvalid  <= 1'b0;
      s_axi_arready <= 1'b0;
      s_axi_rvalid  <= 1'b0;
    end else begin
      s_axi_awready <= aw_en;
      s_axi_wready  <= aw_en;
      if (wr_fire) begin
        s_axi_bvalid <= 1'b1;
      end else if (s_axi_bready) begin
        s_axi_bvalid <= 1'b0;
      end
      s_axi_arready <= ar_en;
      if (rd_fire) begin
        s_axi_rvalid <= 1'b1;
      end else if (s_axi_rready) begin
        s_axi_rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      ref_time <= '0;
      set_req  <= 1'b0;
    end else begin
      set_req <= 1'b0;
      if (wr_fire) begin
        case (s_axi_awaddr)
          sys_time_pkg::REG_TIME_LO: begin
            for (int i = 0; i < 4; i++) begin
              if (s_axi_wstrb[i]) ref_time[8*i +: 8] <= s_axi_wdata[8*i +: 8];
            end
          end
          sys_time_pkg::REG_TIME_HI: begin
            for (int i = 0; i < 4; i++) begin
              if (s_axi_wstrb[i]) ref_time[32 + 8*i +: 8] <= s_axi_wdata[8*i +: 8];
            end
          end
          sys_time_pkg::REG_CTRL: set_req <= s_axi_wstrb[0] & s_axi_wdata[0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (s_axi_araddr)
      sys_time_pkg::REG_TIME_LO: rd_mux = ref_time[31:0];
      sys_time_pkg::REG_TIME_HI: rd_mux = ref_time[63:32];
      sys_time_pkg::REG_STATUS:  rd_mux = {30'd0, lap_valid, set_pending};
      default:                   rd_mux = '0;  // ctrl and holes.
    endcase
  end

  always_ff @(posedge CLK) begin
    if (rd_fire) s_axi_rdata <= rd_mux;
  end

  a_bvalid_hold: assert property (@(posedge CLK) disable iff (!rst_n)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid);

  a_rvalid_hold: assert property (@(posedge CLK) disable iff (!rst_n)
    s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata));

endmodule

`default_nettype wire

/* sys_time_sync.sv */
//////////////////////////////////////////////////
// System time core. Samples the external sync,
// loads time from the lap count when armed, and
// otherwise compares against the expected grid and
// slews by holding or skipping one tick at a time.
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module sys_time_sync (
  input  wire                   CLK,
  input  wire                   rst_n,
  input  wire                   ecat_sync,
  input  wire                   set_req,
  input  wire sys_time_pkg::lap_t lap,
  input  wire                   lap_done,
  output sys_time_pkg::sys_time_t sys_time,
  output logic                  sync,
  output logic                  skip_one,
  output logic                  set_pending,
  output logic                  lap_valid
);

  typedef enum logic [1:0] {IDLE, WAIT_DIFF, CORRECT} state_t;

  state_t state;
  logic [2:0] sync_sr;
  logic load;
  sys_time_pkg::sys_time_t load_time;
  sys_time_pkg::sys_time_t next_sync_time;
  sys_time_pkg::time_diff_t a_diff, b_diff, s_diff;
  sys_time_pkg::time_diff_t a_next, b_next, s_next;
  sys_time_pkg::time_diff_t drift;
  sys_time_pkg::lat_cnt_t diff_cnt;
  sys_time_pkg::lat_cnt_t next_cnt;
  sys_time_pkg::tick_cnt_t half_cnt;
  logic next_busy;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      sync_sr <= '0;
    end else begin
      sync_sr <= {sync_sr[1:0], ecat_sync};
    end
  end

  assign sync = (sync_sr == 3'b011);  // rising edge past the synchronizer.
  assign load = set_pending & lap_valid;
  assign load_time = lap * sys_time_pkg::SYNC_PERIOD_TICKS;

  // drift = expected - local, taken on the sync cycle.
  assign a_diff = load ? {1'b0, load_time} : {1'b0, next_sync_time};
  assign b_diff = load ? {1'b0, load_time} : {1'b0, sys_time + 64'd1};
  assign a_next = {1'b0, next_sync_time};
  assign b_next = sys_time_pkg::time_diff_t'(sys_time_pkg::SYNC_PERIOD_TICKS);

  pipe_addsub #(.SUBTRACT(1'b1)) u_diff (
    .CLK   (CLK),
    .rst_n (rst_n),
    .a     (a_diff),
    .b     (b_diff),
    .s     (s_diff)
  );

  pipe_addsub #(.SUBTRACT(1'b0)) u_next (
    .CLK   (CLK),
    .rst_n (rst_n),
    .a     (a_next),
    .b     (b_next),
    .s     (s_next)
  );

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      sys_time <= '0;
      drift    <= '0;
      diff_cnt <= '0;
      skip_one <= 1'b0;
    end else if (sync) begin
      sys_time <= load ? load_time : sys_time + 64'd1;
      diff_cnt <= '0;
      skip_one <= 1'b0;
      state    <= WAIT_DIFF;
    end else begin
      skip_one <= 1'b0;
      case (state)
        WAIT_DIFF: begin
          sys_time <= sys_time + 64'd1;
          if (diff_cnt == sys_time_pkg::lat_cnt_t'(sys_time_pkg::ADDSUB_LATENCY - 1)) begin
            drift <= s_diff;
            state <= CORRECT;
          end else begin
            diff_cnt <= diff_cnt + 1'b1;
          end
        end
        CORRECT: begin
          if (drift == '0) begin
            sys_time <= sys_time + 64'd1;
            state    <= IDLE;
          end else if (drift[64]) begin
            sys_time <= sys_time;  // ahead of the grid.
            drift    <= drift + 65'sd1;
          end else begin
            sys_time <= sys_time + 64'd2;
            skip_one <= 1'b1;
            drift    <= drift - 65'sd1;
          end
        end
        default: sys_time <= sys_time + 64'd1;
      endcase
    end
  end

  // grid update is launched mid-period so it lands well before the next sync.
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      half_cnt       <= '0;
      next_busy      <= 1'b0;
      next_cnt       <= '0;
      next_sync_time <= '0;
    end else begin
      if (sync) begin
        half_cnt <= sys_time_pkg::tick_cnt_t'(sys_time_pkg::SYNC_PERIOD_TICKS / 2);
      end else if (half_cnt == sys_time_pkg::tick_cnt_t'(sys_time_pkg::SYNC_PERIOD_TICKS - 1)) begin
        half_cnt <= '0;
      end else begin
        half_cnt <= half_cnt + 1'b1;
      end

      if (sync && load) begin
        next_sync_time <= load_time;
        next_busy      <= 1'b0;  // drop any stale update.
      end else if (!sync &&
                   half_cnt == sys_time_pkg::tick_cnt_t'(sys_time_pkg::SYNC_PERIOD_TICKS - 1)) begin
        next_busy <= 1'b1;
        next_cnt  <= '0;
      end else if (next_busy) begin
        if (next_cnt == sys_time_pkg::lat_cnt_t'(sys_time_pkg::ADDSUB_LATENCY - 1)) begin
          next_sync_time <= s_next[63:0];
          next_busy      <= 1'b0;
        end else begin
          next_cnt <= next_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      set_pending <= 1'b0;
      lap_valid   <= 1'b0;
    end else begin
      if (set_req) begin
        set_pending <= 1'b1;
      end else if (sync && load) begin
        set_pending <= 1'b0;
      end
      if (set_req) begin
        lap_valid <= 1'b0;  // new division under way.
      end else if (lap_done) begin
        lap_valid <= 1'b1;
      end
    end
  end

  a_skip_only_behind: assert property (@(posedge CLK) disable iff (!rst_n)
    skip_one |-> ($past(drift) > 65'sd0));

endmodule

`default_nettype wire

/* pipe_addsub.sv */
//////////////////////////////////////////////////
// 65-bit add or subtract with a fixed pipeline
// delay of ADDSUB_LATENCY cycles. SUBTRACT picks
// a - b over a + b. New operands every cycle.
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module pipe_addsub #(
  parameter bit SUBTRACT = 1'b0
) (
  input  wire                       CLK,
  input  wire                       rst_n,
  input  wire sys_time_pkg::time_diff_t a,
  input  wire sys_time_pkg::time_diff_t b,
  output sys_time_pkg::time_diff_t  s
);

  sys_time_pkg::time_diff_t stage [sys_time_pkg::ADDSUB_LATENCY];

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < sys_time_pkg::ADDSUB_LATENCY; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= SUBTRACT ? (a - b) : (a + b);
      // remaining stages only delay the result.
      for (int i = 1; i < sys_time_pkg::ADDSUB_LATENCY; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign s = stage[sys_time_pkg::ADDSUB_LATENCY-1];

endmodule

`default_nettype wire

/* lap_divider.sv */
//////////////////////////////////////////////////
// Restoring divider for reference ns by the sync
// period. One quotient bit per cycle, remainder is
// dropped. lap_done pulses 64 cycles after start.
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module lap_divider (
  input  wire                      CLK,
  input  wire                      rst_n,
  input  wire                      start,
  input  wire sys_time_pkg::sys_time_t ref_time,
  output sys_time_pkg::lap_t       lap,
  output logic                     lap_done
);

  logic [31:0] rem;
  logic [31:0] rem_in;
  sys_time_pkg::lap_t quo_in;
  logic [32:0] trial;
  logic [5:0] bit_cnt;
  logic busy;

  // first step runs straight off ref_time on the start cycle.
  assign rem_in = start ? 32'd0 : rem;
  assign quo_in = start ? ref_time : lap;
  assign trial = {rem_in, quo_in[63]} - {1'b0, sys_time_pkg::SYNC_PERIOD_NS};

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      rem      <= '0;
      lap      <= '0;
      bit_cnt  <= '0;
      busy     <= 1'b0;
      lap_done <= 1'b0;
    end else begin
      lap_done <= 1'b0;
      if (start || busy) begin
        if (trial[32]) begin
          rem <= {rem_in[30:0], quo_in[63]};  // borrow, keep partial remainder.
        end else begin
          rem <= trial[31:0];
        end
        lap <= {quo_in[62:0], ~trial[32]};  // dividend shifts out as quotient shifts in.
        if (start) begin
          bit_cnt <= 6'd1;
          busy    <= 1'b1;
        end else begin
          bit_cnt  <= bit_cnt + 6'd1;
          busy     <= (bit_cnt != 6'd63);
          lap_done <= (bit_cnt == 6'd63);
        end
      end
    end
  end

  a_done_after_start: assert property (@(posedge CLK) disable iff (!rst_n)
    lap_done |-> $past(start, 64));

endmodule

`default_nettype wire

/* sys_time_pkg.sv */
//////////////////////////////////////////////////
// Shared widths, timing constants and register map
// for the sync-locked system time generator.
// Modules reference these with sys_time_pkg:: names.
//////////////////////////////////////////////////
`default_nettype none

package sys_time_pkg;

  localparam logic [31:0] SYNC_PERIOD_NS = 32'd500000;
  localparam int unsigned SYNC_PERIOD_TICKS = 10240;  // 20.48 MHz over one sync period.
  localparam int unsigned ADDSUB_LATENCY = 6;

  typedef logic [63:0] sys_time_t;            // ticks, or ns for the reference.
  typedef logic signed [64:0] time_diff_t;
  typedef logic [63:0] lap_t;                 // whole sync periods.
  typedef logic [$clog2(SYNC_PERIOD_TICKS)-1:0] tick_cnt_t;
  typedef logic [$clog2(ADDSUB_LATENCY)-1:0] lat_cnt_t;

  typedef logic [3:0] axi_addr_t;
  typedef logic [31:0] axi_data_t;

  // register map, byte offsets.
  localparam axi_addr_t REG_TIME_LO = 4'h0;
  localparam axi_addr_t REG_TIME_HI = 4'h4;
  localparam axi_addr_t REG_CTRL = 4'h8;      // bit 0 arms a set.
  localparam axi_addr_t REG_STATUS = 4'hC;    // {lap_valid, set_pending}.

endpackage

`default_nettype wire
